// ==== rtl/rob_defs.sv ====
package rob_defs;

localparam int RB_NUM_ENTS = 8;
localparam int RB_IDX_W    = $clog2(RB_NUM_ENTS);
localparam int MUL_STAGES  = 3;

typedef logic [4:0]          t_rv_reg_addr;
typedef logic [31:0]         t_rv_reg_data;
typedef logic [31:0]         t_paddr;
typedef logic [RB_IDX_W-1:0] t_rob_idx;

// Wrap bit tells full from empty
typedef struct packed {
   logic     wrap;
   t_rob_idx idx;
} t_rob_id;

typedef enum logic [2:0] {
   UOP_ADD,
   UOP_SUB,
   UOP_AND,
   UOP_OR,
   UOP_XOR,
   UOP_MUL,
   UOP_BEQ,
   UOP_BNE
} t_uop;

typedef struct packed {
   logic         valid;
   t_uop         uop;
   t_rv_reg_addr rd;
   t_rv_reg_data src1;
   t_rv_reg_data src2;
   t_paddr       br_tgt;
} t_uinstr;

typedef struct packed {
   logic         valid;
   t_uop         uop;
   t_rv_reg_data src1;
   t_rv_reg_data src2;
   t_rob_id      robid;
} t_exec_req;

typedef struct packed {
   logic         valid;
   t_rob_id      robid;
   t_rv_reg_data result;
   logic         br_taken;
} t_exec_rsp;

// Written once at allocation
typedef struct packed {
   t_uinstr uinstr;
} t_rob_ent_static;

typedef struct packed {
   logic            valid;
   logic            ready;
   t_rv_reg_data    result;
   logic            br_taken;
   t_rob_ent_static s;
} t_rob_ent;

function automatic t_rob_id f_incr_robid(t_rob_id id);
   t_rob_id nxt;
   nxt = id;
   if (id.idx == t_rob_idx'(RB_NUM_ENTS-1)) begin
      nxt.idx  = '0;
      nxt.wrap = ~id.wrap;
   end else begin
      nxt.idx = id.idx + 1'b1;
   end
   return nxt;
endfunction

function automatic logic f_rob_empty(t_rob_id head, t_rob_id tail);
   return head == tail;
endfunction

function automatic logic f_rob_full(t_rob_id head, t_rob_id tail);
   return (head.idx == tail.idx) && (head.wrap != tail.wrap);
endfunction

endpackage

// ==== rtl/rob_entry.sv ====
`timescale 1ns/10ps

module rob_entry
   import rob_defs::*;
(
   input  logic            clk,
   input  logic            reset,

   input  t_rob_id         idx,

   input  logic            e_alloc_de1,
   input  t_rob_ent_static q_alloc_s_de1,

   input  t_exec_rsp       alu_rsp,
   input  t_exec_rsp       mul_rsp,

   input  logic            retire_rb1,
   input  logic            flush_rb1,

   output t_rob_ent        rob_entry
);

logic            valid_q;
logic            ready_q;
t_rob_ent_static s_q;
t_rv_reg_data    result_q;
logic            br_taken_q;

logic            alu_hit;
logic            mul_hit;

// Completion match on the index only
assign alu_hit = valid_q & alu_rsp.valid & (alu_rsp.robid.idx == idx.idx);
assign mul_hit = valid_q & mul_rsp.valid & (mul_rsp.robid.idx == idx.idx);

always_ff @(posedge clk) begin
   if (reset) begin
      valid_q <= 1'b0;
      ready_q <= 1'b0;
   end else if (e_alloc_de1) begin
      valid_q <= 1'b1;
      ready_q <= 1'b0;
   end else if (retire_rb1 | flush_rb1) begin
      valid_q <= 1'b0;
      ready_q <= 1'b0;
   end else if (alu_hit | mul_hit) begin
      ready_q <= 1'b1;
   end
end

always_ff @(posedge clk) begin
   if (e_alloc_de1) begin
      s_q <= q_alloc_s_de1;
   end
   if (alu_hit) begin
      result_q   <= alu_rsp.result;
      br_taken_q <= alu_rsp.br_taken;
   end else if (mul_hit) begin
      result_q   <= mul_rsp.result;
      br_taken_q <= mul_rsp.br_taken;
   end
end

assign rob_entry = '{
   valid:    valid_q,
   ready:    ready_q,
   result:   result_q,
   br_taken: br_taken_q,
   s:        s_q
};

endmodule

// ==== rtl/exec_alu.sv ====
`timescale 1ns/10ps

module exec_alu
   import rob_defs::*;
(
   input  logic      clk,
   input  logic      reset,

   input  t_exec_req req,
   input  logic      flush_rb1,

   output t_exec_rsp rsp
);

t_rv_reg_data alu_result;
logic         alu_br_taken;

logic         rsp_valid_q;
t_rob_id      rsp_robid_q;
t_rv_reg_data rsp_result_q;
logic         rsp_br_taken_q;

always_comb begin
   alu_result   = '0;
   alu_br_taken = 1'b0;
   case (req.uop)
      UOP_ADD: alu_result = req.src1 + req.src2;
      UOP_SUB: alu_result = req.src1 - req.src2;
      UOP_AND: alu_result = req.src1 & req.src2;
      UOP_OR:  alu_result = req.src1 | req.src2;
      UOP_XOR: alu_result = req.src1 ^ req.src2;
      // Branches produce no register result
      UOP_BEQ: alu_br_taken = (req.src1 == req.src2);
      UOP_BNE: alu_br_taken = (req.src1 != req.src2);
      default: begin
         alu_result   = '0;
         alu_br_taken = 1'b0;
      end
   endcase
end

always_ff @(posedge clk) begin
   if (reset) begin
      rsp_valid_q <= 1'b0;
   end else begin
      rsp_valid_q <= req.valid & ~flush_rb1;
   end
end

always_ff @(posedge clk) begin
   rsp_robid_q    <= req.robid;
   rsp_result_q   <= alu_result;
   rsp_br_taken_q <= alu_br_taken;
end

assign rsp = '{
   valid:    rsp_valid_q,
   robid:    rsp_robid_q,
   result:   rsp_result_q,
   br_taken: rsp_br_taken_q
};

endmodule

// ==== rtl/exec_mul.sv ====
`timescale 1ns/10ps

module exec_mul
   import rob_defs::*;
(
   input  logic      clk,
   input  logic      reset,

   input  t_exec_req req,
   input  logic      flush_rb1,

   output t_exec_rsp rsp
);

logic [MUL_STAGES-1:0] vld_q;
t_rob_id               id_q [MUL_STAGES];

// Stage 1 operands
t_rv_reg_data a_q;
t_rv_reg_data b_q;

// Stage 2 partial products, only the low 32 bits are kept
t_rv_reg_data p_ll_q;
logic [15:0]  p_x_q;
logic [31:0]  m_lh;
logic [31:0]  m_hl;

// Stage 3 result
t_rv_reg_data res_q;

assign m_lh = a_q[15:0] * b_q[31:16];
assign m_hl = a_q[31:16] * b_q[15:0];

// Flush kills everything in flight
always_ff @(posedge clk) begin
   if (reset | flush_rb1) begin
      vld_q <= '0;
   end else begin
      vld_q <= {vld_q[MUL_STAGES-2:0], req.valid & (req.uop == UOP_MUL)};
   end
end

always_ff @(posedge clk) begin
   id_q[0] <= req.robid;
   for (int i = 1; i < MUL_STAGES; i++) begin
      id_q[i] <= id_q[i-1];
   end
end

always_ff @(posedge clk) begin
   a_q    <= req.src1;
   b_q    <= req.src2;
   p_ll_q <= a_q[15:0] * b_q[15:0];
   p_x_q  <= m_lh[15:0] + m_hl[15:0];
   res_q  <= p_ll_q + {p_x_q, 16'h0000};
end

assign rsp = '{
   valid:    vld_q[MUL_STAGES-1],
   robid:    id_q[MUL_STAGES-1],
   result:   res_q,
   br_taken: 1'b0
};

endmodule

// ==== rtl/rob.sv ====
`timescale 1ns/10ps

module rob
   import rob_defs::*;
(
   input  logic         clk,
   input  logic         reset,

   input  t_uinstr      uinstr_de1,

   input  t_exec_rsp    alu_rsp,
   input  t_exec_rsp    mul_rsp,
   output t_exec_req    alu_req,
   output t_exec_req    mul_req,
   output logic         flush_rb1,

   output logic         rob_full,

   output t_uinstr      uinstr_rb1,
   output logic         wren_rb1,
   output t_rv_reg_addr wraddr_rb1,
   output t_rv_reg_data wrdata_rb1,

   output logic         br_mispred_rb1,
   output t_paddr       br_tgt_rb1
);

t_rob_id head_id;
t_rob_id tail_id;
t_rob_id head_id_nxt;
t_rob_id tail_id_nxt;
t_rob_id head_id_inc;

t_rob_ent entries [RB_NUM_ENTS-1:0];
t_rob_ent head_ent;

logic                   q_alloc_de1;
logic [RB_NUM_ENTS-1:0] e_alloc_de1;
t_rob_ent_static        q_alloc_s_de1;
t_exec_req              new_req_de1;

logic                   rob_empty;
logic                   retire_rb1;
logic [RB_NUM_ENTS-1:0] e_retire_rb1;
logic                   head_is_br;

// Retire decision on the head entry
assign head_ent    = entries[head_id.idx];
assign head_id_inc = f_incr_robid(head_id);
assign rob_empty   = f_rob_empty(head_id, tail_id);
assign retire_rb1  = ~rob_empty & head_ent.ready;
assign head_is_br  = head_ent.s.uinstr.uop inside {UOP_BEQ, UOP_BNE};

// Predicted not-taken, so any taken branch mispredicts
assign flush_rb1    = retire_rb1 & head_is_br & head_ent.br_taken;
assign e_retire_rb1 = retire_rb1 ? (RB_NUM_ENTS'(1) << head_id.idx) : '0;

// New instruction is dropped when full or in a flush cycle
assign q_alloc_de1 = uinstr_de1.valid & ~rob_full & ~flush_rb1;
assign e_alloc_de1 = q_alloc_de1 ? (RB_NUM_ENTS'(1) << tail_id.idx) : '0;

always_comb begin
   q_alloc_s_de1.uinstr = uinstr_de1;
end

// Steering by uop
assign new_req_de1 = '{
   valid: q_alloc_de1,
   uop:   uinstr_de1.uop,
   src1:  uinstr_de1.src1,
   src2:  uinstr_de1.src2,
   robid: tail_id
};

always_comb begin
   alu_req       = new_req_de1;
   mul_req       = new_req_de1;
   alu_req.valid = new_req_de1.valid & (uinstr_de1.uop != UOP_MUL);
   mul_req.valid = new_req_de1.valid & (uinstr_de1.uop == UOP_MUL);
end

always_comb begin
   head_id_nxt = head_id;
   tail_id_nxt = tail_id;
   if (flush_rb1) begin
      head_id_nxt = head_id_inc;
      tail_id_nxt = head_id_inc;
   end else begin
      if (retire_rb1) begin
         head_id_nxt = head_id_inc;
      end
      if (q_alloc_de1) begin
         tail_id_nxt = f_incr_robid(tail_id);
      end
   end
end

always_ff @(posedge clk) begin
   if (reset) begin
      head_id  <= '0;
      tail_id  <= '0;
      rob_full <= 1'b0;
   end else begin
      head_id  <= head_id_nxt;
      tail_id  <= tail_id_nxt;
      rob_full <= f_rob_full(head_id_nxt, tail_id_nxt);
   end
end

// Retire port, one cycle after the decision
always_ff @(posedge clk) begin
   if (reset) begin
      uinstr_rb1     <= '0;
      wren_rb1       <= 1'b0;
      br_mispred_rb1 <= 1'b0;
   end else begin
      uinstr_rb1     <= retire_rb1 ? head_ent.s.uinstr : '0;
      wren_rb1       <= retire_rb1 & ~head_is_br & (head_ent.s.uinstr.rd != '0);
      br_mispred_rb1 <= flush_rb1;
   end
end

always_ff @(posedge clk) begin
   wraddr_rb1 <= head_ent.s.uinstr.rd;
   wrdata_rb1 <= head_ent.result;
   br_tgt_rb1 <= head_ent.s.uinstr.br_tgt;
end

for (genvar i = 0; i < RB_NUM_ENTS; i++) begin : g_rob_ents
   t_rob_id ent_id;
   assign ent_id = '{wrap: 1'b0, idx: t_rob_idx'(i)};

   rob_entry rbent (
      .clk,
      .reset,
      .idx           ( ent_id          ),
      .e_alloc_de1   ( e_alloc_de1[i]  ),
      .q_alloc_s_de1 ( q_alloc_s_de1   ),
      .alu_rsp       ( alu_rsp         ),
      .mul_rsp       ( mul_rsp         ),
      .retire_rb1    ( e_retire_rb1[i] ),
      .flush_rb1     ( flush_rb1       ),
      .rob_entry     ( entries[i]      )
   );
end

endmodule

// ==== rtl/rob_core.sv ====
`timescale 1ns/10ps

module rob_core
   import rob_defs::*;
(
   input  logic         clk,
   input  logic         reset,

   input  t_uinstr      uinstr_de1,
   output logic         rob_full,

   output t_uinstr      uinstr_rb1,
   output logic         wren_rb1,
   output t_rv_reg_addr wraddr_rb1,
   output t_rv_reg_data wrdata_rb1,

   output logic         br_mispred_rb1,
   output t_paddr       br_tgt_rb1
);

t_exec_req alu_req;
t_exec_req mul_req;
t_exec_rsp alu_rsp;
t_exec_rsp mul_rsp;
logic      flush_rb1;

rob i_rob (
   .clk,
   .reset,
   .uinstr_de1,
   .alu_rsp,
   .mul_rsp,
   .alu_req,
   .mul_req,
   .flush_rb1,
   .rob_full,
   .uinstr_rb1,
   .wren_rb1,
   .wraddr_rb1,
   .wrdata_rb1,
   .br_mispred_rb1,
   .br_tgt_rb1
);

exec_alu i_alu (
   .clk,
   .reset,
   .req       ( alu_req   ),
   .flush_rb1 ( flush_rb1 ),
   .rsp       ( alu_rsp   )
);

exec_mul i_mul (
   .clk,
   .reset,
   .req       ( mul_req   ),
   .flush_rb1 ( flush_rb1 ),
   .rsp       ( mul_rsp   )
);

endmodule

// ==== tests/rob_core_tb.sv ====
`timescale 1ns/10ps

module rob_core_tb
   import rob_defs::*;
();

typedef struct packed {
   logic         wren;
   logic         mispred;
   t_rv_reg_data result;
} t_retire_exp;

logic         clk;
logic         reset;
t_uinstr      uinstr_de1;
logic         rob_full;
t_uinstr      uinstr_rb1;
logic         wren_rb1;
t_rv_reg_addr wraddr_rb1;
t_rv_reg_data wrdata_rb1;
logic         br_mispred_rb1;
t_paddr       br_tgt_rb1;

integer  seed = 46;
t_uinstr exp_q [$];
int      errors = 0;
int      tests_failed = 0;
int      issued = 0;
int      retired = 0;
int      mispreds = 0;
int      cycles = 0;
int      peak_occ = 0;

rob_core i_dut (
   .clk,
   .reset,
   .uinstr_de1,
   .rob_full,
   .uinstr_rb1,
   .wren_rb1,
   .wraddr_rb1,
   .wrdata_rb1,
   .br_mispred_rb1,
   .br_tgt_rb1
);

initial clk = 1'b0;
always #2 clk = ~clk;

// Expected architectural effect of one instruction
function automatic t_retire_exp predict_retire(t_uinstr u);
   t_retire_exp e;
   logic [63:0] prod;
   logic        is_br;
   logic        taken;
   e     = '0;
   taken = 1'b0;
   is_br = (u.uop == UOP_BEQ) || (u.uop == UOP_BNE);
   prod  = u.src1 * u.src2;
   case (u.uop)
      UOP_ADD: e.result = u.src1 + u.src2;
      UOP_SUB: e.result = u.src1 - u.src2;
      UOP_AND: e.result = u.src1 & u.src2;
      UOP_OR:  e.result = u.src1 | u.src2;
      UOP_XOR: e.result = u.src1 ^ u.src2;
      UOP_MUL: e.result = prod[31:0];
      UOP_BEQ: taken = (u.src1 == u.src2);
      UOP_BNE: taken = (u.src1 != u.src2);
      default: e.result = '0;
   endcase
   e.wren    = !is_br && (u.rd != '0);
   e.mispred = is_br && taken;
   return e;
endfunction

// mix 0 is ALU only, 1 adds multiplies, 2 adds branches
task automatic make_uinstr(input int mix, output t_uinstr u);
   int sel;
   u        = '0;
   u.valid  = 1'b1;
   u.rd     = t_rv_reg_addr'($random(seed));
   u.src1   = $random(seed);
   u.src2   = $random(seed);
   u.br_tgt = $random(seed);
   sel      = {$random(seed)} % 16;
   if (mix > 0 && sel < 5) begin
      u.uop = UOP_MUL;
   end else if (mix > 1 && sel >= 14) begin
      u.uop = (sel == 14) ? UOP_BEQ : UOP_BNE;
      if ($random(seed) & 1) begin
         u.src2 = u.src1;
      end
   end else begin
      u.uop = t_uop'({$random(seed)} % 5);
   end
endtask

task automatic make_branch(input t_uop op, input logic taken, output t_uinstr u);
   make_uinstr(0, u);
   u.uop  = op;
   u.src2 = ((op == UOP_BEQ) == taken) ? u.src1 : ~u.src1;
endtask

// Holds back while the ROB reports full
task automatic present(input t_uinstr u);
   @(negedge clk);
   while (rob_full) begin
      uinstr_de1 = '0;
      @(negedge clk);
   end
   uinstr_de1 = u;
   issued++;
endtask

task automatic drain();
   @(negedge clk);
   uinstr_de1 = '0;
   @(posedge clk);
   while (exp_q.size() != 0) begin
      @(posedge clk);
   end
   // A few more cycles to catch stray retires
   repeat (4) @(posedge clk);
endtask

task automatic report_test(input int num, input string name, input int err_before);
   if (errors == err_before) begin
      $display("test %0d %s: ok", num, name);
   end else begin
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
      tests_failed++;
   end
endtask

// Accepted instructions enter program order at the allocating edge
always @(posedge clk) begin
   if (!reset && uinstr_de1.valid) begin
      exp_q.push_back(uinstr_de1);
   end
end

always @(negedge clk) begin : check_retire
   t_uinstr     u;
   t_retire_exp e;
   if (!reset) begin
      if (uinstr_rb1.valid || wren_rb1 || br_mispred_rb1) begin
         retired++;
         if (exp_q.size() == 0) begin
            $display("Retire seen with nothing outstanding, uinstr_rb1 0x%h", uinstr_rb1);
            errors++;
         end else begin
            u = exp_q.pop_front();
            e = predict_retire(u);
            if (uinstr_rb1 !== u) begin
               $display("FAILED uinstr_rb1 exp 0x%h got 0x%h", u, uinstr_rb1);
               errors++;
            end
            if (wren_rb1 !== e.wren) begin
               $display("FAILED wren_rb1 exp 0x%h got 0x%h", e.wren, wren_rb1);
               errors++;
            end
            if (e.wren && wraddr_rb1 !== u.rd) begin
               $display("FAILED wraddr_rb1 exp 0x%h got 0x%h", u.rd, wraddr_rb1);
               errors++;
            end
            if (e.wren && wrdata_rb1 !== e.result) begin
               $display("FAILED wrdata_rb1 exp 0x%08h got 0x%08h", e.result, wrdata_rb1);
               errors++;
            end
            if (br_mispred_rb1 !== e.mispred) begin
               $display("FAILED br_mispred_rb1 exp 0x%h got 0x%h", e.mispred, br_mispred_rb1);
               errors++;
            end
            if (e.mispred && br_tgt_rb1 !== u.br_tgt) begin
               $display("FAILED br_tgt_rb1 exp 0x%08h got 0x%08h", u.br_tgt, br_tgt_rb1);
               errors++;
            end
         end
         // Everything still queued is younger than the branch
         if (br_mispred_rb1) begin
            mispreds++;
            exp_q.delete();
         end
      end
      if (exp_q.size() > peak_occ) begin
         peak_occ = exp_q.size();
      end
      if (rob_full !== (exp_q.size() == RB_NUM_ENTS)) begin
         $display("FAILED rob_full exp 0x%h got 0x%h", exp_q.size() == RB_NUM_ENTS, rob_full);
         errors++;
      end
   end
end

always @(posedge clk) begin
   cycles++;
   if (cycles > issued * 12 + 200) begin
      $display("Run stopped after %0d cycles with %0d instructions never retired",
               cycles, exp_q.size());
      $display("Test failed");
      $finish;
   end
end

initial begin
   t_uinstr u;
   int      err0;
   int      ret0;
   int      mis0;
   uinstr_de1 = '0;
   reset      = 1'b1;
   repeat (2) @(posedge clk);
   @(negedge clk);
   reset = 1'b0;

   err0 = errors;
   for (int i = 0; i < 24; i++) begin
      make_uinstr(0, u);
      if (i % 4 == 3) begin
         u.rd = '0;
      end
      present(u);
   end
   drain();
   report_test(1, "alu stream", err0);

   err0 = errors;
   for (int i = 0; i < 40; i++) begin
      make_uinstr(1, u);
      present(u);
   end
   drain();
   report_test(2, "mul and alu stream", err0);

   err0 = errors;
   ret0 = retired;
   peak_occ = 0;
   for (int i = 0; i < 16; i++) begin
      make_uinstr(1, u);
      u.uop = UOP_MUL;
      present(u);
   end
   drain();
   if (retired - ret0 != 16) begin
      $display("Multiply burst retired %0d of 16 instructions", retired - ret0);
      errors++;
   end
   // Each multiply holds its entry from allocation until its retire
   if (peak_occ != MUL_STAGES + 1) begin
      $display("Multiply burst peaked at %0d outstanding instructions instead of %0d",
               peak_occ, MUL_STAGES + 1);
      errors++;
   end
   report_test(3, "full level", err0);

   // Two older multiplies and an add, then younger work behind the branch
   err0 = errors;
   ret0 = retired;
   mis0 = mispreds;
   for (int i = 0; i < 3; i++) begin
      make_uinstr(1, u);
      u.uop = (i < 2) ? UOP_MUL : UOP_ADD;
      present(u);
   end
   make_branch(UOP_BNE, 1'b1, u);
   present(u);
   for (int i = 0; i < 4; i++) begin
      make_uinstr(1, u);
      if (i % 2 == 0) begin
         u.uop = UOP_MUL;
      end
      present(u);
   end
   drain();
   for (int i = 0; i < 8; i++) begin
      make_uinstr(1, u);
      present(u);
   end
   drain();
   if (mispreds - mis0 != 1) begin
      $display("Expected one mispredict pulse but saw %0d", mispreds - mis0);
      errors++;
   end
   if (retired - ret0 != 12) begin
      $display("Expected 12 retires around the taken branch but saw %0d", retired - ret0);
      errors++;
   end
   report_test(4, "taken branch", err0);

   err0 = errors;
   ret0 = retired;
   mis0 = mispreds;
   make_uinstr(1, u);
   u.uop = UOP_MUL;
   present(u);
   make_branch(UOP_BEQ, 1'b0, u);
   present(u);
   for (int i = 0; i < 5; i++) begin
      make_uinstr(1, u);
      present(u);
   end
   make_branch(UOP_BNE, 1'b0, u);
   present(u);
   make_uinstr(0, u);
   present(u);
   drain();
   if (mispreds != mis0) begin
      $display("Not-taken branch raised %0d mispredict pulses", mispreds - mis0);
      errors++;
   end
   if (retired - ret0 != 9) begin
      $display("Expected 9 retires around not-taken branches but saw %0d", retired - ret0);
      errors++;
   end
   report_test(5, "not-taken branch", err0);

   err0 = errors;
   for (int i = 0; i < 300; i++) begin
      make_uinstr(2, u);
      present(u);
   end
   drain();
   report_test(6, "random mix", err0);

   $display("%0d tests, %0d failed, %0d issued, %0d retired, %0d mispredicts, %0d errors",
            6, tests_failed, issued, retired, mispreds, errors);
   if (errors == 0) begin
      $display("Test passed");
   end else begin
      $display("Test failed");
   end
   $finish;
end

endmodule

// ==== flist.f ====
rtl/rob_defs.sv
rtl/rob_entry.sv
rtl/exec_alu.sv
rtl/exec_mul.sv
rtl/rob.sv
rtl/rob_core.sv
tests/rob_core_tb.sv
